/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_port_select
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Done: no errors

SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
verilog/psel_pkg.sv
verilog/carry_sum_gen.sv
verilog/pop_counter.sv
verilog/min_finder.sv
verilog/onehot_to_bin.sv
verilog/port_select_pipe.sv
verification/tb_port_select.sv

/* verification/port_select_trace.txt */
# valid req occ0..occ7 payload0..payload7, then expected any grant_idx req_count sole payload
# all fields hex with port 0 first; expected fields are 0 when valid is 0
1 ff 10 0c 08 14 03 1f 07 09 a0 a1 a2 a3 a4 a5 a6 a7 1 4 8 0 a4
1 0f 05 04 06 02 00 00 00 00 10 11 12 13 14 15 16 17 1 3 4 0 13
1 ff 07 07 07 07 07 07 07 07 20 21 22 23 24 25 26 27 1 0 8 0 20
1 ff 0a 0b 01 0c 0d 01 0e 0f 30 31 32 33 34 35 36 37 1 2 8 0 32
1 f0 00 00 00 00 03 03 03 03 40 41 42 43 44 45 46 47 1 4 4 0 44
1 c0 01 01 01 01 01 01 09 09 50 51 52 53 54 55 56 57 1 6 2 0 56
1 80 00 00 00 00 00 00 00 1f 60 61 62 63 64 65 66 67 1 7 1 1 67
1 01 1f 00 00 00 00 00 00 00 70 71 72 73 74 75 76 77 1 0 1 1 70
1 20 00 00 00 00 00 10 00 00 80 81 82 83 84 85 86 87 1 5 1 1 85
1 00 04 02 1f 00 06 09 01 03 90 91 92 93 94 95 96 97 0 0 0 0 00
1 81 04 00 00 00 00 00 00 03 b0 b1 b2 b3 b4 b5 b6 b7 1 7 2 0 b7
1 1f 09 08 07 08 09 00 00 00 c0 c1 c2 c3 c4 c5 c6 c7 1 2 5 0 c2
1 f8 00 00 00 11 12 10 13 10 d0 d1 d2 d3 d4 d5 d6 d7 1 5 5 0 d5
1 55 1e 00 1d 00 1c 00 1b 00 e0 e1 e2 e3 e4 e5 e6 e7 1 6 4 0 e6
1 aa 00 02 00 02 00 01 00 01 f0 f1 f2 f3 f4 f5 f6 f7 1 5 4 0 f5
0 ff 01 02 03 04 05 06 07 08 00 00 00 00 00 00 00 00 0 0 0 0 00
0 0f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 0 0 0 00
1 02 1e 1f 1e 1e 1e 1e 1e 1e 11 22 33 44 55 66 77 88 1 1 1 1 22
0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 0 0 0 00
1 ff 1f 1f 1f 1f 1f 1f 1f 1e 01 02 03 04 05 06 07 08 1 7 8 0 08
1 ff 1f 1f 1f 1f 1f 1f 1f 1f 5a 5b 5c 5d 5e 5f 60 61 1 0 8 0 5a
1 00 00 00 00 00 00 00 00 00 ff fe fd fc fb fa f9 f8 0 0 0 0 00
1 7f 03 03 03 03 03 03 02 00 20 21 22 23 24 25 26 27 1 6 7 0 26
1 3c 00 00 0f 0e 0e 0f 00 00 48 49 4a 4b 4c 4d 4e 4f 1 3 4 0 4b
1 fe 00 05 04 03 02 01 01 02 70 71 72 73 74 75 76 77 1 5 7 0 75
1 03 08 08 00 00 00 00 00 00 a8 a9 aa ab ac ad ae af 1 0 2 0 a8
1 c3 04 05 00 00 00 00 05 04 18 19 1a 1b 1c 1d 1e 1f 1 0 4 0 18
0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 0 0 0 00
1 10 1f 1f 1f 1f 1f 1f 1f 1f 31 32 33 34 35 36 37 38 1 4 1 1 35
1 e7 0c 0b 0a 00 00 09 08 08 c8 c9 ca cb cc cd ce cf 1 6 6 0 ce
1 ff 1f 1e 1d 1c 1b 1a 19 18 00 11 22 33 44 55 66 77 1 7 8 0 77
1 ff 18 19 1a 1b 1c 1d 1e 1f 00 11 22 33 44 55 66 77 1 0 8 0 00
1 21 02 00 00 00 00 01 00 00 90 91 92 93 94 95 96 97 1 5 2 0 95
0 ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 0 0 0 00
1 08 00 00 00 1f 00 00 00 00 b8 b9 ba bb bc bd be bf 1 3 1 1 bb
1 9c 00 00 06 06 05 00 00 05 60 61 62 63 64 65 66 67 1 4 4 0 64

/* verification/tb_port_select.sv */
`timescale 1ns/1ps

module tb_port_select;

    import psel_pkg::*;

    localparam int NFIELDS    = 23;  // valid req occ[8] payload[8] any idx count sole payload
    localparam int NUM_RANDOM = 8;
    localparam int LATENCY    = 2;

    typedef struct packed {
        logic [15:0] num;  // test number, 0 for idle filler
        logic        valid;
        logic        any;
        idx_t        idx;
        cnt_t        cnt;
        logic        sole;
        data_t       payload;
    } expect_t;

    logic      clk;
    logic      arst_n;
    psel_req_t req_in;
    psel_rsp_t rsp;
    psel_req_t stim_q[$];
    expect_t   exp_q[$];
    expect_t   inflight[$];  // bundles inside the pipeline
    logic      loaded       = 1'b0;
    int        error_count  = 0;
    int        tests_done   = 0;
    int        tests_failed = 0;

    port_select_pipe dut0 (
        .clk    (clk),
        .arst_n (arst_n),
        .req_in (req_in),
        .rsp    (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // lowest occupancy among requesters, the first one found keeps ties
    function automatic expect_t expected_response(input psel_req_t r, input int num);
        expect_t e;
        int      best;
        e = '0;
        best = -1;
        e.num = 16'(num);
        e.valid = r.valid;
        for (int i = 0; i < NPORT; i++) begin
            if (r.valid && r.req[i]) begin
                e.cnt = e.cnt + cnt_t'(1);
                if (best < 0 || r.occ[i] < r.occ[best]) begin
                    best = i;
                end
            end
        end
        if (best >= 0) begin
            e.any = 1'b1;
            e.idx = idx_t'(best);
            e.payload = r.payload[best];
        end
        e.sole = (e.cnt == cnt_t'(1));
        return e;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %0d ns %s expected %0h got %0h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_response(input expect_t e);
        int errors_before;
        errors_before = error_count;
        compare_field("rsp.valid", 32'(e.valid), 32'(rsp.valid));
        if (e.valid) begin
            compare_field("rsp.any", 32'(e.any), 32'(rsp.any));
            compare_field("rsp.grant", e.any ? 32'(1) << e.idx : 32'(0), 32'(rsp.grant));
            compare_field("rsp.grant_idx", 32'(e.idx), 32'(rsp.grant_idx));
            compare_field("rsp.req_count", 32'(e.cnt), 32'(rsp.req_count));
            compare_field("rsp.sole", 32'(e.sole), 32'(rsp.sole));
        end
        if (e.valid && e.any) begin
            compare_field("rsp.payload", 32'(e.payload), 32'(rsp.payload));
        end
        if (e.num != '0) begin
            tests_done++;
            if (error_count != errors_before) begin
                tests_failed++;
            end
            $display("test %0d: %s", e.num, (error_count == errors_before) ? "pass" : "fail");
        end
    endtask

    task automatic load_trace(output logic ok);
        int         fd;
        int         nf;
        int         num;
        string      line;
        logic [7:0] f [NFIELDS];
        psel_req_t  r;
        expect_t    e;
        ok = 1'b1;
        num = 0;
        fd = $fopen("verification/port_select_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/port_select_trace.txt");
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                nf = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                    f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
                    f[21], f[22]);
                if (nf == NFIELDS) begin
                    num++;
                    r = '0;
                    r.valid = f[0][0];
                    r.req = f[1];
                    for (int i = 0; i < NPORT; i++) begin
                        r.occ[i] = f[2 + i][4:0];
                        r.payload[i] = f[10 + i];
                    end
                    e = '0;
                    e.num = 16'(num);
                    e.valid = r.valid;
                    e.any = f[18][0];
                    e.idx = f[19][2:0];
                    e.cnt = f[20][3:0];
                    e.sole = f[21][0];
                    e.payload = f[22];
                    stim_q.push_back(r);
                    exp_q.push_back(e);
                end else if (nf > 0) begin  // comment and blank lines give 0 or -1
                    $display("trace line after test %0d has %0d fields, not %0d", num, nf,
                             NFIELDS);
                    ok = 1'b0;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        logic        ok;
        logic [31:0] rng;
        psel_req_t   r;
        arst_n = 1'b0;
        req_in = '0;
        rng = 32'hd4ebe8a8;
        for (int i = 0; i < LATENCY; i++) begin  // idle bundles right after reset
            stim_q.push_back('0);
            exp_q.push_back('0);
        end
        load_trace(ok);
        for (int k = 0; k < NUM_RANDOM; k++) begin
            rng = next_rand(rng);
            r = '0;
            r.valid = (rng[31:29] != 3'd0);  // mostly valid
            r.req = rng[7:0];
            for (int i = 0; i < NPORT; i++) begin
                rng = next_rand(rng);
                r.occ[i] = (k % 2 == 1) ? occ_t'(rng[2:0]) : rng[4:0];  // narrow range, ties
                r.payload[i] = rng[15:8];
            end
            stim_q.push_back(r);
            exp_q.push_back(expected_response(r, exp_q.size() - LATENCY + 1));
        end
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        compare_field("rsp.valid", 32'(0), 32'(rsp.valid));
        compare_field("rsp.any", 32'(0), 32'(rsp.any));
        compare_field("rsp.sole", 32'(0), 32'(rsp.sole));
        compare_field("rsp.grant", 32'(0), 32'(rsp.grant));
        $display("test reset: %s", (error_count == 0) ? "pass" : "fail");
        if (error_count != 0) begin
            tests_failed++;
        end
        if (!ok) begin
            error_count++;
        end
        for (int n = 0; n < stim_q.size() + LATENCY + 1; n++) begin
            @(posedge clk);
            #1;  // outputs settled, inputs change here
            if (inflight.size() == LATENCY) begin
                check_response(inflight.pop_front());
            end
            req_in = (n < stim_q.size()) ? stim_q[n] : '0;
            inflight.push_back((n < stim_q.size()) ? exp_q[n] : '0);
        end
        $display("%0d tests, %0d failed, %0d mismatches", tests_done + 1, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #((stim_q.size() + 20) * 10);  // one clock per vector plus margin
        $display("watchdog timeout, responses stopped before the trace ended");
        $display("Done: errors found");
        $finish;
    end

endmodule

/* verilog/carry_sum_gen.sv */
`timescale 1ns/1ps

module carry_sum_gen (
    input  logic [6:0] in,
    output logic [2:0] abc,
    output logic       s
);

    logic [3:0] lo;
    logic [2:0] hi;
    logic [2:0] lo_cnt;  // 0 to 4
    logic [1:0] hi_cnt;  // 0 to 3

    assign {hi, lo} = in;

    assign lo_cnt = 3'(lo[0]) + 3'(lo[1]) + 3'(lo[2]) + 3'(lo[3]);
    assign hi_cnt = 2'(hi[0]) + 2'(hi[1]) + 2'(hi[2]);

    // popcount(in) == s + 2 * (a + b + c)
    assign s      = lo_cnt[0] ^ hi_cnt[0];          // odd total
    assign abc[2] = (lo_cnt > 3'd1);                // pair in low group
    assign abc[1] = (hi_cnt > 2'd1);                // pair in high group
    assign abc[0] = (lo_cnt == 3'd4)                // second pair in low group
                  | (lo_cnt[0] & hi_cnt[0]);        // two odd leftovers pair up

endmodule

/* verilog/min_finder.sv */
`timescale 1ns/1ps

module min_finder #(
    parameter int NUM   = psel_pkg::NPORT,
    parameter int KEY_W = psel_pkg::KEY_W
) (
    input  logic [NUM*KEY_W-1:0] keys,
    output logic [NUM-1:0]       min_onehot
);

    logic [KEY_W-1:0] key   [NUM];
    logic [NUM-2:0]   beats [NUM];  // row i: port i holds against each other port

    always_comb begin
        for (int i = 0; i < NUM; i++) begin
            key[i] = keys[i*KEY_W +: KEY_W];
        end
    end

    // upper triangle compares i against j+1, lower triangle mirrors it
    always_comb begin
        for (int i = 0; i < NUM; i++) begin
            for (int j = 0; j < NUM - 1; j++) begin
                if (i > j) begin
                    beats[i][j] = ~beats[j][i-1];  // strict less, so lower index keeps ties
                end else begin
                    beats[i][j] = (key[i] <= key[j+1]);
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM; i++) begin
            min_onehot[i] = &beats[i];
        end
    end

endmodule

/* verilog/onehot_to_bin.sv */
`timescale 1ns/1ps

module onehot_to_bin #(
    parameter int ONEHOT_W = psel_pkg::NPORT,
    parameter int BIN_W    = psel_pkg::IDX_W
) (
    input  logic [ONEHOT_W-1:0] onehot,
    output logic [BIN_W-1:0]    bin
);

    logic [BIN_W-1:0] masked [ONEHOT_W];  // own index gated by select bit

    always_comb begin
        for (int i = 0; i < ONEHOT_W; i++) begin
            masked[i] = BIN_W'(i) & {BIN_W{onehot[i]}};
        end
    end

    // all-zero select falls out as index 0
    always_comb begin
        bin = '0;
        for (int i = 0; i < ONEHOT_W; i++) begin
            bin |= masked[i];  // column-wise or
        end
    end

endmodule

/* verilog/pop_counter.sv */
`timescale 1ns/1ps

// (7,3) parallel counter
module pc_7_3 (
    input  logic [6:0] in,
    output logic [2:0] count
);

    logic [2:0] abc;

    carry_sum_gen cs0 (
        .in  (in),
        .abc (abc),
        .s   (count[0])
    );

    // each carry weighs two
    assign count[2:1] = 2'(abc[2]) + 2'(abc[1]) + 2'(abc[0]);

endmodule

// (15,4) parallel counter
module pop_counter (
    input  logic [14:0] in,
    output logic [3:0]  count
);

    logic [2:0] abc0;
    logic [2:0] abc1;
    logic       s0;
    logic       s1;
    logic       spare_carry;  // carry out of the sum-bit add

    carry_sum_gen cs0 (
        .in  (in[6:0]),
        .abc (abc0),
        .s   (s0)
    );

    carry_sum_gen cs1 (
        .in  (in[13:7]),
        .abc (abc1),
        .s   (s1)
    );

    // weight-one bits: two sums and the leftover input
    assign {spare_carry, count[0]} = 2'(in[14]) + 2'(s0) + 2'(s1);

    // all seven weight-two bits go one level down
    pc_7_3 pc_sub (
        .in    ({abc0, abc1, spare_carry}),
        .count (count[3:1])
    );

endmodule

/* verilog/port_select_pipe.sv */
`timescale 1ns/1ps

module port_select_pipe (
    input  logic                clk,
    input  logic                arst_n,
    input  psel_pkg::psel_req_t req_in,
    output psel_pkg::psel_rsp_t rsp
);

    import psel_pkg::*;

    localparam int PC_IN_W = 15;  // (15,4) counter input

    typedef struct packed {
        logic      valid;
        port_vec_t grant;
        cnt_t      count;
    } s1_ctrl_t;

    typedef struct packed {
        logic      valid;
        logic      any;
        port_vec_t grant;
        idx_t      grant_idx;
        cnt_t      req_count;
        logic      sole;
    } s2_ctrl_t;

    logic [NPORT*KEY_W-1:0] keys;
    port_vec_t              min_onehot;
    s1_ctrl_t               s1_next;
    s1_ctrl_t               s1_q;
    data_t [NPORT-1:0]      s1_payload_q;
    idx_t                   grant_idx;
    s2_ctrl_t               s2_next;
    s2_ctrl_t               s2_q;
    data_t                  s2_payload_q;

    // stage 1: pick the least occupied requester and count requests

    // idle ports get the top key bit so they always lose
    always_comb begin
        for (int i = 0; i < NPORT; i++) begin
            keys[i*KEY_W +: KEY_W] = {~req_in.req[i], req_in.occ[i]};
        end
    end

    min_finder #(
        .NUM   (NPORT),
        .KEY_W (KEY_W)
    ) u_min (
        .keys       (keys),
        .min_onehot (min_onehot)
    );

    pop_counter u_cnt (
        .in    ({{(PC_IN_W - NPORT){1'b0}}, req_in.req}),
        .count (s1_next.count)
    );

    assign s1_next.valid = req_in.valid;
    assign s1_next.grant = min_onehot & req_in.req;  // no winner when nobody requests

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_q <= '0;
        end else begin
            s1_q <= s1_next;
        end
    end

    always_ff @(posedge clk) begin
        s1_payload_q <= req_in.payload;
    end

    // stage 2: encode the grant and pick the payload

    onehot_to_bin #(
        .ONEHOT_W (NPORT),
        .BIN_W    (IDX_W)
    ) u_enc (
        .onehot (s1_q.grant),
        .bin    (grant_idx)
    );

    always_comb begin
        s2_next.valid     = s1_q.valid;
        s2_next.any       = (s1_q.count != '0);
        s2_next.grant     = s1_q.grant;
        s2_next.grant_idx = grant_idx;
        s2_next.req_count = s1_q.count;
        s2_next.sole      = (s1_q.count == cnt_t'(1));  // exactly one requester
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_q <= '0;
        end else begin
            s2_q <= s2_next;
        end
    end

    always_ff @(posedge clk) begin
        s2_payload_q <= s1_payload_q[grant_idx];  // port 0 payload when idle
    end

    always_comb begin
        rsp.valid     = s2_q.valid;
        rsp.any       = s2_q.any;
        rsp.grant     = s2_q.grant;
        rsp.grant_idx = s2_q.grant_idx;
        rsp.req_count = s2_q.req_count;
        rsp.sole      = s2_q.sole;
        rsp.payload   = s2_payload_q;
    end

endmodule

/* verilog/psel_pkg.sv */
package psel_pkg;

    localparam int NPORT  = 8;
    localparam int OCC_W  = 5;
    localparam int KEY_W  = OCC_W + 1;  // idle flag above occupancy
    localparam int DATA_W = 8;
    localparam int IDX_W  = 3;
    localparam int CNT_W  = 4;

    typedef logic [NPORT-1:0]  port_vec_t;
    typedef logic [OCC_W-1:0]  occ_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [IDX_W-1:0]  idx_t;
    typedef logic [CNT_W-1:0]  cnt_t;

    typedef struct packed {
        logic                  valid;
        port_vec_t             req;
        occ_t  [NPORT-1:0]     occ;
        data_t [NPORT-1:0]     payload;
    } psel_req_t;

    typedef struct packed {
        logic      valid;
        logic      any;
        port_vec_t grant;      // one-hot, zero when nobody requests
        idx_t      grant_idx;
        cnt_t      req_count;
        logic      sole;
        data_t     payload;
    } psel_rsp_t;

endpackage
